// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_conv5x5
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= === FAIL ===

EXE  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard hdl/*.svh tb/*.svh)

.PHONY: all compile run clean

all: run

compile: $(EXE)

$(EXE): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result; a crashed run counts as a failure too
run: $(EXE)
	@./$(EXE) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/conv5x5_top.sv ====
`default_nettype none

`include "conv_cfg.svh"

module conv5x5_top (
  input  logic             clk,
  input  logic             rst,
  input  logic [2:0]       kernel_sel,                      // kernel code, 5..7 ignored
  input  conv_pkg::rows_t  rows_in,                         // five image rows, one pixel each
  output conv_pkg::pixel_t pix_out                          // filtered pixel every clock
);

  conv_pkg::coeff_table_t coeffs;                           // current kernel
  conv_pkg::rows_t        rows_aligned;                     // rows after the skew delays
  conv_pkg::acc_t         sum;                              // raw cascade result

  kernel_rom u_kernel_rom (
    .clk        (clk),
    .rst        (rst),
    .kernel_sel (kernel_sel),
    .coeffs     (coeffs)
  );

  row_delay u_row_delay (
    .clk          (clk),
    .rst          (rst),
    .rows_in      (rows_in),
    .rows_aligned (rows_aligned)
  );

  mac_cascade u_mac_cascade (
    .clk          (clk),
    .rst          (rst),
    .rows_aligned (rows_aligned),
    .coeffs       (coeffs),
    .sum          (sum)
  );

  // drop the fraction bits and keep 8 integer bits, wrapping without saturation;
  // the output register gives the pixel its 27-k cycle latency
  always_ff @(posedge clk) begin
    if (rst) begin
      pix_out <= '0;
    end else begin
      pix_out <= sum[`CONV_FRAC_BITS + `CONV_PIX_W - 1 : `CONV_FRAC_BITS];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/conv_cfg.svh ====
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// datapath widths
`define CONV_PIX_W     8                              // one pixel, unsigned
`define CONV_COEFF_W   18                             // signed fixed point coefficient
`define CONV_ACC_W     48                             // partial sum along the cascade

// kernel geometry
`define CONV_SIDE      5                              // kernel side, also the row delay step
`define CONV_TAPS      (`CONV_SIDE * `CONV_SIDE)      // one MAC tap per coefficient

// coefficient format s.int.frac, the sign bit is not counted
`define CONV_INT_BITS  1                              // legal range 0 to 17
`define CONV_FRAC_BITS (17 - `CONV_INT_BITS)          // fraction bits left after the sign

`endif

// ==== hdl/conv_pkg.sv ====
`default_nettype none

`include "conv_cfg.svh"

package conv_pkg;

  typedef logic [`CONV_PIX_W-1:0] pixel_t;            // unsigned pixel value
  typedef logic signed [`CONV_COEFF_W-1:0] coeff_t;   // s.int.frac coefficient
  typedef logic signed [`CONV_ACC_W-1:0] acc_t;       // cascade partial sum

  // one column of the image window, one pixel per image row
  typedef struct packed {
    pixel_t row0;                                     // top row
    pixel_t row1;
    pixel_t row2;                                     // center row
    pixel_t row3;
    pixel_t row4;                                     // bottom row
  } rows_t;

  // whole kernel, tap = side*row + col
  typedef coeff_t [`CONV_TAPS-1:0] coeff_table_t;

  // kernel selector codes, 5..7 unnamed and ignored
  typedef enum logic [2:0] {
    kernel_center     = 3'd0,                         // pass the center pixel
    kernel_gauss      = 3'd1,                         // binomial blur
    kernel_box        = 3'd2,                         // homogeneous average
    kernel_left_right = 3'd3,                         // horizontal gradient
    kernel_top_bottom = 3'd4                          // vertical gradient
  } kernel_e;

endpackage

`default_nettype wire

// ==== hdl/kernel_rom.sv ====
`default_nettype none

`include "conv_cfg.svh"

module kernel_rom (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [2:0]             kernel_sel,                // raw selector, codes 5..7 ignored
  output conv_pkg::coeff_table_t coeffs                     // registered kernel table
);

  conv_pkg::kernel_e sel_k;                                 // selector seen as a kernel code

  assign sel_k = conv_pkg::kernel_e'(kernel_sel);

  // binomial row 1,4,6,4,1
  function automatic int binom(input int idx);
    int w;
    case (idx)
      0, 4:    w = 1;
      1, 3:    w = 4;
      2:       w = 6;
      default: w = 0;
    endcase
    return w;
  endfunction

  // antisymmetric gradient -1,-2,0,2,1
  function automatic int grad(input int idx);
    int w;
    case (idx)
      0:       w = -1;
      1:       w = -2;
      3:       w = 2;
      4:       w = 1;
      default: w = 0;
    endcase
    return w;
  endfunction

  // fills all taps for one kernel in s.int.frac format
  function automatic conv_pkg::coeff_table_t build_table(input conv_pkg::kernel_e kind);
    conv_pkg::coeff_table_t tbl;
    int one;                                                // 1.0 in fixed point
    int val;
    int mid;
    one = 1 << `CONV_FRAC_BITS;
    mid = `CONV_SIDE / 2;
    tbl = '0;
    for (int r = 0; r < `CONV_SIDE; r++) begin
      for (int k = 0; k < `CONV_SIDE; k++) begin
        case (kind)
          conv_pkg::kernel_center:
            val = (r == mid && k == mid) ? one : 0;         // single 1.0 in the middle
          conv_pkg::kernel_gauss:
            val = binom(r) * binom(k) * one / 256;          // weights sum to 256
          conv_pkg::kernel_box:
            val = (one + `CONV_TAPS / 2) / `CONV_TAPS;      // 1/25 rounded to nearest
          conv_pkg::kernel_left_right:
            val = grad(k) * one / 32;                       // same weights on every row
          conv_pkg::kernel_top_bottom:
            val = grad(r) * one / 32;                       // same weights on every column
          default:
            val = 0;
        endcase
        tbl[`CONV_SIDE * r + k] = conv_pkg::coeff_t'(val);
      end
    end
    return tbl;
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      coeffs <= '0;                                         // zero kernel, output stays 0
    end else begin
      case (sel_k)
        conv_pkg::kernel_center,
        conv_pkg::kernel_gauss,
        conv_pkg::kernel_box,
        conv_pkg::kernel_left_right,
        conv_pkg::kernel_top_bottom: begin
          coeffs <= build_table(sel_k);                     // load the chosen kernel
        end
        default: begin
          coeffs <= coeffs;                                 // unnamed codes keep the old table
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hdl/mac_cascade.sv ====
`default_nettype none

`include "conv_cfg.svh"

module mac_cascade (
  input  logic                   clk,
  input  logic                   rst,
  input  conv_pkg::rows_t        rows_aligned,              // one pixel per row, delay matched
  input  conv_pkg::coeff_table_t coeffs,                    // tap = 5*row + col
  output conv_pkg::acc_t         sum                        // full sum from the last tap
);

  conv_pkg::pixel_t row_pix   [`CONV_SIDE];                 // aligned rows as an array
  conv_pkg::acc_t   sum_chain [`CONV_TAPS];                 // sum register of every tap

  assign row_pix[0] = rows_aligned.row0;
  assign row_pix[1] = rows_aligned.row1;
  assign row_pix[2] = rows_aligned.row2;
  assign row_pix[3] = rows_aligned.row3;
  assign row_pix[4] = rows_aligned.row4;

  // Each tap is a pixel/coefficient register, a product register and a sum register.
  // All taps of one row see the same pixel; the hop from tap to tap shifts the window
  // by one column, so column 0 ends up with the oldest sample of that row.
  for (genvar t = 0; t < `CONV_TAPS; t++) begin : g_tap
    localparam int ROW = t / `CONV_SIDE;                    // image row feeding this tap

    conv_pkg::pixel_t            pix_q;                     // stage 1 pixel
    conv_pkg::coeff_t            coeff_q;                   // stage 1 coefficient
    logic signed [`CONV_PIX_W:0] pix_s;                     // pixel with a zero sign bit
    conv_pkg::acc_t              prod_q;                    // stage 2 product
    conv_pkg::acc_t              sum_q;                     // stage 3 running sum
    conv_pkg::acc_t              sum_in;                    // partial sum from tap t-1

    if (t == 0) begin : g_first
      assign sum_in = '0;                                   // chain starts empty
    end else begin : g_next
      assign sum_in = sum_chain[t-1];
    end

    assign pix_s = {1'b0, pix_q};                           // pixels are unsigned

    always_ff @(posedge clk) begin
      if (rst) begin
        pix_q   <= '0;
        coeff_q <= '0;
        prod_q  <= '0;
        sum_q   <= '0;
      end else begin
        pix_q   <= row_pix[ROW];
        coeff_q <= coeffs[t];
        prod_q  <= pix_s * coeff_q;                         // signed, sign extended to 48 bits
        sum_q   <= prod_q + sum_in;                         // add onto the cascade
      end
    end

    assign sum_chain[t] = sum_q;
  end

  assign sum = sum_chain[`CONV_TAPS-1];                     // last tap holds the whole window

endmodule

`default_nettype wire

// ==== hdl/row_delay.sv ====
`default_nettype none

`include "conv_cfg.svh"

module row_delay (
  input  logic            clk,
  input  logic            rst,
  input  conv_pkg::rows_t rows_in,                          // newest column
  output conv_pkg::rows_t rows_aligned                      // row r held back 5*r cycles
);

  conv_pkg::pixel_t col_in  [`CONV_SIDE];                   // rows as an indexable array
  conv_pkg::pixel_t col_out [`CONV_SIDE];

  assign col_in[0] = rows_in.row0;
  assign col_in[1] = rows_in.row1;
  assign col_in[2] = rows_in.row2;
  assign col_in[3] = rows_in.row3;
  assign col_in[4] = rows_in.row4;

  assign col_out[0] = col_in[0];                            // top row needs no delay

  // lower rows enter the cascade later, so they wait longer here
  for (genvar r = 1; r < `CONV_SIDE; r++) begin : g_row
    localparam int DEPTH = `CONV_SIDE * r;                  // 5, 10, 15, 20 stages

    conv_pkg::pixel_t sr [DEPTH];                           // sr[0] newest

    always_ff @(posedge clk) begin
      if (rst) begin
        for (int i = 0; i < DEPTH; i++) begin
          sr[i] <= '0;
        end
      end else begin
        sr[0] <= col_in[r];
        for (int i = 1; i < DEPTH; i++) begin
          sr[i] <= sr[i-1];                                 // shift one place per clock
        end
      end
    end

    assign col_out[r] = sr[DEPTH-1];                        // oldest entry leaves
  end

  assign rows_aligned.row0 = col_out[0];
  assign rows_aligned.row1 = col_out[1];
  assign rows_aligned.row2 = col_out[2];
  assign rows_aligned.row3 = col_out[3];
  assign rows_aligned.row4 = col_out[4];

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hdl
+incdir+tb
hdl/conv_pkg.sv
hdl/kernel_rom.sv
hdl/row_delay.sv
hdl/mac_cascade.sv
hdl/conv5x5_top.sv
tb/tb_conv5x5.sv

// ==== tb/conv_ref.svh ====
`ifndef CONV_REF_SVH
`define CONV_REF_SVH

// one xorshift32 step, a nonzero state never reaches zero
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// pixel of image row r taken from one column
function automatic conv_pkg::pixel_t pick_row(input conv_pkg::rows_t col, input int r);
  conv_pkg::pixel_t p;
  case (r)
    0:       p = col.row0;
    1:       p = col.row1;
    2:       p = col.row2;
    3:       p = col.row3;
    default: p = col.row4;
  endcase
  return p;
endfunction

// coefficient of tap (r,k) in s.int.frac, straight from the kernel definitions
function automatic longint kernel_coeff(input conv_pkg::kernel_e kind, input int r, input int k);
  longint one;
  longint c;
  int     binom [5];
  int     grad [5];
  int     mid;
  one   = longint'(1) << `CONV_FRAC_BITS;                 // 1.0
  binom = '{1, 4, 6, 4, 1};                               // sums to 16, so 256 over 2-D
  grad  = '{-1, -2, 0, 2, 1};
  mid   = `CONV_SIDE / 2;
  case (kind)
    conv_pkg::kernel_center:     c = (r == mid && k == mid) ? one : '0;
    conv_pkg::kernel_gauss:      c = longint'(binom[r] * binom[k]) * one / 256;
    conv_pkg::kernel_box:        c = (2 * one + 25) / 50;    // one/25 rounded half up
    conv_pkg::kernel_left_right: c = longint'(grad[k]) * one / 32;
    conv_pkg::kernel_top_bottom: c = longint'(grad[r]) * one / 32;
    default:                     c = '0;
  endcase
  return c;
endfunction

// full-precision window sum, win[j] is the column sampled j edges back
function automatic longint window_sum(input conv_pkg::kernel_e kind,
                                      input conv_pkg::rows_t win [`CONV_TAPS + 3]);
  longint acc;
  longint px;
  acc = 0;
  for (int r = 0; r < `CONV_SIDE; r++) begin
    for (int k = 0; k < `CONV_SIDE; k++) begin
      px  = longint'(pick_row(win[`CONV_TAPS + 2 - k], r));   // column k is 27-k edges old
      acc = acc + kernel_coeff(kind, r, k) * px;
    end
  end
  return acc;
endfunction

// output pixel: drop the fraction, keep 8 bits with wrap
function automatic conv_pkg::pixel_t expected_pixel(input conv_pkg::kernel_e kind,
                                                    input conv_pkg::rows_t win [`CONV_TAPS + 3]);
  return conv_pkg::pixel_t'(window_sum(kind, win) >>> `CONV_FRAC_BITS);
endfunction

// value seen when every pixel of the window equals v
function automatic conv_pkg::pixel_t flat_field_pixel(input conv_pkg::kernel_e kind,
                                                      input conv_pkg::pixel_t v);
  longint coeff_sum;
  coeff_sum = 0;
  for (int t = 0; t < `CONV_TAPS; t++) begin
    coeff_sum = coeff_sum + kernel_coeff(kind, t / `CONV_SIDE, t % `CONV_SIDE);
  end
  return conv_pkg::pixel_t'((coeff_sum * longint'(v)) >>> `CONV_FRAC_BITS);
endfunction

`endif

// ==== tb/tb_conv5x5.sv ====
`default_nettype none

`include "conv_cfg.svh"

module tb_conv5x5;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HIST_DEPTH     = `CONV_TAPS + 3;        // oldest column is 27 edges back
  localparam int HOLD_CYCLES    = 30;                    // output mixed after a kernel change
  localparam int RESET_CYCLES   = 4;
  localparam int ZERO_CYCLES    = 40;                    // zero rows after reset
  localparam int PHASE_CYCLES   = 230;
  localparam int FLAT_CYCLES    = 60;                    // constant field part of the box phase
  localparam int INVALID_CYCLES = 40;                    // per unnamed code
  localparam int TIMEOUT_CYCLES = 2000;                  // six phases of ~230 plus margin

  `include "conv_ref.svh"

  logic              clk;
  logic              rst;
  logic [2:0]        kernel_sel;
  conv_pkg::rows_t   rows_in;
  conv_pkg::pixel_t  pix_out;

  conv_pkg::rows_t   hist [$];                           // hist[0] sampled at the last edge
  conv_pkg::rows_t   win [HIST_DEPTH];
  conv_pkg::kernel_e cur_kernel;                         // kernel the model applies
  conv_pkg::pixel_t  exp_pix;
  conv_pkg::pixel_t  flat_val;
  logic              chk_en   = 1'b0;                    // model compare armed for this cycle
  logic              zero_chk = 1'b1;
  logic              model_on   = 1'b0;
  logic              center_on  = 1'b0;
  logic              flat_on    = 1'b0;
  logic              invalid_on = 1'b0;
  logic [31:0]       rng_state;
  int                hold_cnt  = 0;
  int                cycle_cnt = 0;
  int                model_errs = 0;                     // from the model assertion
  int                zero_errs  = 0;                     // from the zero assertion
  int                main_errs  = 0;                     // immediate checks and coverage
  int                model_checks    = 0;
  int                zero_checks     = 0;
  int                center_checks   = 0;
  int                flat_checks     = 0;
  int                invalid_checks  = 0;
  int                negative_checks = 0;

  conv5x5_top uut (
    .clk        (clk),
    .rst        (rst),
    .kernel_sel (kernel_sel),
    .rows_in    (rows_in),
    .pix_out    (pix_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;                               // 4 ns period
  end

  // sampled at negedge so pix_out and the armed expectation are settled
  zero_out_check: assert property (@(negedge clk) disable iff (!zero_chk) pix_out == '0)
    else begin
      $display("Mismatch pix_out: got %h expected %h at cycle %0d", pix_out, 8'h00, cycle_cnt);
      zero_errs++;
    end

  model_check: assert property (@(negedge clk) disable iff (!chk_en) pix_out == exp_pix)
    else begin
      $display("Mismatch pix_out: got %h expected %h (kernel %s) at cycle %0d",
               pix_out, exp_pix, cur_kernel.name(), cycle_cnt);
      model_errs++;
    end

  function automatic conv_pkg::rows_t random_rows();
    conv_pkg::rows_t r;
    r = '0;
    for (int i = 0; i < `CONV_SIDE; i++) begin
      rng_state = xorshift32(rng_state);
      r = {r[4*`CONV_PIX_W-1:0], rng_state[`CONV_PIX_W-1:0]};   // shift in one row
    end
    return r;
  endfunction

  // center kernel passes row 2 through 25 edges late
  task automatic check_center();
    conv_pkg::pixel_t want;
    want = pick_row(hist[HIST_DEPTH - 1 - `CONV_SIDE / 2], 2);
    center_checks++;
    assert (pix_out == want) else begin
      $display("Mismatch pix_out: got %h expected %h (row2 delayed) at cycle %0d",
               pix_out, want, cycle_cnt);
      main_errs++;
    end
  endtask

  task automatic check_flat();
    conv_pkg::pixel_t want;
    want = flat_field_pixel(cur_kernel, flat_val);
    flat_checks++;
    assert (pix_out == want) else begin
      $display("Mismatch pix_out: got %h expected %h (flat field %h) at cycle %0d",
               pix_out, want, flat_val, cycle_cnt);
      main_errs++;
    end
  endtask

  // wait one edge, log what the DUT sampled, arm the checks, then drive the next column
  task automatic advance_cycle(input conv_pkg::rows_t next_rows);
    @(posedge clk);
    #1;
    hist.push_front(rows_in);
    void'(hist.pop_back());
    for (int j = 0; j < HIST_DEPTH; j++) begin
      win[j] = hist[j];
    end
    if (hold_cnt > 0) begin
      hold_cnt--;
    end
    exp_pix = expected_pixel(cur_kernel, win);
    chk_en  = model_on && (hold_cnt == 0);
    if (zero_chk) begin
      zero_checks++;
    end
    if (chk_en) begin
      model_checks++;
      if (invalid_on) invalid_checks++;
      if (window_sum(cur_kernel, win) < 0) negative_checks++;   // wrapped negative result
      if (center_on) check_center();
      if (flat_on) check_flat();
    end
    rows_in = next_rows;
  endtask

  task automatic run_random(input int n);
    repeat (n) begin
      advance_cycle(random_rows());
    end
  endtask

  task automatic select_kernel(input conv_pkg::kernel_e kind);
    kernel_sel = kind;                                   // sampled on the next edge
    cur_kernel = kind;
    hold_cnt   = HOLD_CYCLES;
  endtask

  task automatic require_reached(input int count, input string what);
    if (count == 0) begin
      $display("check never ran: %s", what);
      main_errs++;
    end
  endtask

  initial begin
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run still busy after %0d cycles", cycle_cnt);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    rst        = 1'b1;
    kernel_sel = 3'd0;
    rows_in    = '0;
    rng_state  = 32'd18;
    cur_kernel = conv_pkg::kernel_center;
    for (int i = 0; i < HIST_DEPTH; i++) begin
      hist.push_back('0);                                // pipeline is cleared by reset
    end

    repeat (RESET_CYCLES) advance_cycle('0);
    rst = 1'b0;
    repeat (ZERO_CYCLES) advance_cycle('0);              // center loads and output stays 0
    zero_chk = 1'b0;

    model_on  = 1'b1;
    center_on = 1'b1;
    run_random(PHASE_CYCLES);
    center_on = 1'b0;

    select_kernel(conv_pkg::kernel_box);
    flat_val = 8'hc7;
    flat_on  = 1'b1;
    repeat (FLAT_CYCLES) advance_cycle(conv_pkg::rows_t'({`CONV_SIDE{flat_val}}));
    flat_on = 1'b0;
    run_random(PHASE_CYCLES - FLAT_CYCLES);

    select_kernel(conv_pkg::kernel_gauss);
    run_random(PHASE_CYCLES);

    invalid_on = 1'b1;                                   // gauss must stay loaded
    for (int code = 5; code < 8; code++) begin
      kernel_sel = 3'(code);
      run_random(INVALID_CYCLES);
    end
    invalid_on = 1'b0;

    select_kernel(conv_pkg::kernel_left_right);
    run_random(PHASE_CYCLES);
    select_kernel(conv_pkg::kernel_top_bottom);
    run_random(PHASE_CYCLES);
    model_on = 1'b0;
    @(negedge clk);                                      // last armed compare samples here
    #1;

    require_reached(zero_checks, "zero output");
    require_reached(model_checks, "model compare");
    require_reached(center_checks, "center pass-through");
    require_reached(flat_checks, "box flat field");
    require_reached(invalid_checks, "unnamed kernel codes");
    require_reached(negative_checks, "negative sums");

    $display("errors: model %0d zero %0d other %0d; checks: model %0d zero %0d center %0d flat %0d",
             model_errs, zero_errs, main_errs, model_checks, zero_checks, center_checks,
             flat_checks);
    if (model_errs + zero_errs + main_errs == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
